/* vlc_stream.f */
source/vlc_pkg.sv
source/bit_packer.sv
source/word_fifo.sv
source/byte_escaper.sv
source/stream_ctrl_regs.sv
source/vlc_stream_top.sv
test/tb_vlc_stream.sv

/* Makefile */
TOP = tb_vlc_stream
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlc_stream.f \
		-Mdir obj_dir -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no result line in log"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlc_stream.f

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_vlc_stream.sv */
////////////////////
// testbench for the vlc stream top with reference packing model,
// byte monitor, register checks and watchdog
////////////////////
`timescale 1ns/100ps

module tb_vlc_stream;

    localparam int rand_blocks    = 8;    // escape off, random data
    localparam int esc_blocks     = 6;    // escape on, all-ones codewords
    localparam int max_cw         = 12;   // codewords per random block
    localparam int bp_cw          = 60;   // codewords in the stalled block
    localparam int total_blocks   = rand_blocks + 4 + esc_blocks + 3;
    localparam int total_cw       = (rand_blocks + esc_blocks + 2) * max_cw + 7 + bp_cw;
    localparam int timeout_cycles = 200 * total_blocks + 40 * total_cw;

    logic               xclk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    vlc_pkg::cw_beat_t  in_beat;
    logic               out_valid;
    logic               out_ready;
    logic [7:0]         out_data;
    logic               blk_done;
    logic               cfg_we;
    vlc_pkg::reg_addr_t cfg_addr;
    logic [31:0]        cfg_wdata;
    logic [31:0]        cfg_rdata;

    logic [31:0]                  stim_seed;     // lcg state for stimulus
    logic [vlc_pkg::cw_width-1:0] cw_bits [64];  // codewords of the current block
    int                           cw_len [64];
    int                           cw_n;
    logic [7:0]                   exp_q[$];      // expected bytes, in output order
    int                           blk_q[$];      // expected byte count per block
    int                           exp_total;     // stuffed zeros included
    int                           flushes;
    int                           blocks_seen;
    int                           mismatch_cnt;
    int                           error_cnt;
    logic                         stall_req;     // asks the ready driver for a long stall
    logic                         stall_window;  // codewords of the stalled block going in
    logic                         saw_ready_low;

    vlc_stream_top dut (
        .xclk      (xclk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .blk_done  (blk_done),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        xclk = 1'b0;
        forever #50 xclk = ~xclk;               // 100 ns period
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        stim_seed = lcg(stim_seed);
        return lo + int'(stim_seed[31:8]) % (hi - lo + 1);   // upper bits, better spread
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        error_cnt++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic report_counts();
        $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, error_cnt);
    endtask

    function automatic int emit_byte(input logic [7:0] b, input logic esc);
        exp_q.push_back(b);
        if (esc && b == 8'hff) begin
            exp_q.push_back(8'h00);             // marker escape
            return 2;
        end
        return 1;
    endfunction

    // bitwise model: codewords msb first, zero padded tail, optional escaping
    function automatic int pack_block(input logic esc);
        logic [7:0] cur;
        int         nbits;
        int         cnt;
        cur   = 8'h00;
        nbits = 0;
        cnt   = 0;
        for (int k = 0; k < cw_n; k++) begin
            for (int i = 0; i < cw_len[k]; i++) begin
                cur = {cur[6:0], cw_bits[k][vlc_pkg::cw_width-1-i]};
                nbits++;
                if (nbits == 8) begin
                    cnt += emit_byte(cur, esc);
                    cur   = 8'h00;
                    nbits = 0;
                end
            end
        end
        if (nbits != 0)
            cnt += emit_byte(cur << (8 - nbits), esc);   // residue rounded up to a byte
        return cnt;
    endfunction

    task automatic fill_block(input int n, input logic ones);
        cw_n = n;
        for (int k = 0; k < n; k++) begin
            cw_len[k] = rand_range(1, vlc_pkg::cw_width);
            stim_seed = lcg(stim_seed);
            cw_bits[k] = ones ? '1 : stim_seed[31:5];    // bits below len are junk
        end
    endtask

    task automatic send_beat(input vlc_pkg::cw_op_t op,
                             input logic [vlc_pkg::cw_width-1:0] bits, input int len);
        @(negedge xclk);
        in_valid     = 1'b1;
        in_beat.op   = op;
        in_beat.bits = bits;
        in_beat.len  = len[4:0];
        @(posedge xclk);
        while (!in_ready)                       // held until accepted
            @(posedge xclk);
    endtask

    task automatic run_block(input logic esc, input logic watch);
        int nbytes;
        nbytes = pack_block(esc);
        blk_q.push_back(nbytes);
        exp_total += nbytes;
        flushes++;
        for (int k = 0; k < cw_n; k++) begin
            send_beat(vlc_pkg::OP_CODE, cw_bits[k], cw_len[k]);
            if (watch)
                stall_window = 1'b1;            // fifo starts filling from here
        end
        stall_window = 1'b0;
        stim_seed = lcg(stim_seed);
        send_beat(vlc_pkg::OP_FLUSH, stim_seed[31:5], int'(stim_seed[4:0]));
    endtask

    task automatic drain();
        @(negedge xclk);
        in_valid = 1'b0;
        while (exp_q.size() != 0 || blocks_seen != flushes)
            @(posedge xclk);
        repeat (4) @(posedge xclk);
    endtask

    task automatic write_reg(input vlc_pkg::reg_addr_t a, input logic [31:0] d);
        @(negedge xclk);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(negedge xclk);
        cfg_we = 1'b0;
    endtask

    task automatic read_reg(input vlc_pkg::reg_addr_t a, output logic [31:0] v);
        @(negedge xclk);
        cfg_addr = a;
        @(posedge xclk);
        v = cfg_rdata;                          // combinational read, stable by now
    endtask

    // out_ready driver, one long stall on request, else ready about 3 of 4 cycles
    initial begin
        logic [31:0] rdy_seed;
        int          hold;
        logic        hold_taken;
        rdy_seed   = 32'h5bf44842;
        hold       = 0;
        hold_taken = 1'b0;
        out_ready  = 1'b0;
        forever begin
            @(negedge xclk);
            if (stall_req && !hold_taken) begin
                hold       = 150;
                hold_taken = 1'b1;
            end
            rdy_seed = lcg(rdy_seed);
            if (hold > 0) begin
                out_ready = 1'b0;
                hold--;
            end else begin
                out_ready = (rdy_seed[31:30] != 2'b00);
            end
        end
    end

    // monitor and comparator on output transfers and block ends
    initial begin
        int blk_bytes;
        blk_bytes     = 0;
        blocks_seen   = 0;
        saw_ready_low = 1'b0;
        forever begin
            @(posedge xclk);
            if (!rst) begin
                if (stall_window && !in_ready)
                    saw_ready_low = 1'b1;
                if (out_valid && out_ready) begin
                    blk_bytes++;
                    if (exp_q.size() == 0)
                        report_error("output byte arrived with no byte expected");
                    else
                        check_value("out_data", {24'b0, out_data}, {24'b0, exp_q.pop_front()});
                end
                if (blk_done) begin
                    blocks_seen++;
                    if (blk_q.size() == 0)
                        report_error("blk_done pulsed with no block pending");
                    else
                        check_value("bytes in block", blk_bytes, blk_q.pop_front());
                    blk_bytes = 0;
                end
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge xclk);
        $display("ERROR: watchdog expired after %0d cycles, stream did not finish",
                 timeout_cycles);
        report_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_beat      = '0;
        cfg_we       = 1'b0;
        cfg_addr     = vlc_pkg::REG_CTRL;
        cfg_wdata    = '0;
        stim_seed    = 32'h5bf44842;
        cw_n         = 0;
        exp_total    = 0;
        flushes      = 0;
        mismatch_cnt = 0;
        error_cnt    = 0;
        stall_req    = 1'b0;
        stall_window = 1'b0;
        repeat (5) @(negedge xclk);
        rst = 1'b0;

        repeat (4) begin                        // idle after reset
            @(posedge xclk);
            if (out_valid)
                report_error("out_valid high after reset with no input");
        end
        check_value("in_ready after reset", {31'b0, in_ready}, 32'd1);
        read_reg(vlc_pkg::REG_CTRL, rd);
        check_value("REG_CTRL after reset", rd, 32'd1);

        write_reg(vlc_pkg::REG_CTRL, 32'd0);    // random data, no escaping
        for (int b = 0; b < rand_blocks; b++) begin
            fill_block(rand_range(1, max_cw), 1'b0);
            run_block(1'b0, 1'b0);
        end
        drain();

        fill_block(1, 1'b0);                    // 5-bit residue, one byte
        cw_len[0] = 5;
        run_block(1'b0, 1'b0);
        fill_block(2, 1'b0);                    // 20 bits, three bytes
        cw_len[0] = 13;
        cw_len[1] = 7;
        run_block(1'b0, 1'b0);
        cw_n = 0;                               // second flush in a row, empty block
        run_block(1'b0, 1'b0);
        fill_block(4, 1'b0);                    // 84 bits over word edges
        cw_len[0] = 27;
        cw_len[1] = 27;
        cw_len[2] = 27;
        cw_len[3] = 3;
        run_block(1'b0, 1'b0);
        drain();

        write_reg(vlc_pkg::REG_CTRL, 32'd1);    // all ones, escaping on
        for (int b = 0; b < esc_blocks; b++) begin
            fill_block(rand_range(1, max_cw), 1'b1);
            run_block(1'b1, 1'b0);
        end
        drain();

        stall_req = 1'b1;                       // long output stall, fifo must fill
        repeat (2) @(negedge xclk);
        fill_block(bp_cw, 1'b0);
        run_block(1'b1, 1'b1);
        for (int b = 0; b < 2; b++) begin
            fill_block(rand_range(1, max_cw), 1'b0);
            run_block(1'b1, 1'b0);
        end
        drain();
        if (!saw_ready_low)
            report_error("in_ready never fell while out_ready was held low");

        read_reg(vlc_pkg::REG_BYTES, rd);
        check_value("REG_BYTES", rd, exp_total);
        read_reg(vlc_pkg::REG_BLOCKS, rd);
        check_value("REG_BLOCKS", rd, flushes);
        write_reg(vlc_pkg::REG_BYTES, 32'hffff_ffff);
        read_reg(vlc_pkg::REG_BYTES, rd);
        check_value("REG_BYTES after clear", rd, 32'd0);
        write_reg(vlc_pkg::REG_BLOCKS, 32'hffff_ffff);
        read_reg(vlc_pkg::REG_BLOCKS, rd);
        check_value("REG_BLOCKS after clear", rd, 32'd0);

        report_counts();
        if (mismatch_cnt == 0 && error_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* source/vlc_stream_top.sv */
////////////////////
// packer, word fifo, escaper and registers
////////////////////
`timescale 1ns/100ps

module vlc_stream_top (
    input  logic               xclk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  vlc_pkg::cw_beat_t  in_beat,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [7:0]         out_data,
    output logic               blk_done,
    input  logic               cfg_we,
    input  vlc_pkg::reg_addr_t cfg_addr,
    input  logic [31:0]        cfg_wdata,
    output logic [31:0]        cfg_rdata
);

    logic                  beat_fire;       // beat transferred this edge
    logic                  pk_valid;
    vlc_pkg::packed_word_t pk_word;
    logic                  pop;
    logic                  pop_valid;
    vlc_pkg::packed_word_t pop_word;
    logic                  space_ok;
    logic                  escape_en;
    logic                  byte_fire;

    assign beat_fire = in_valid && in_ready;

    // one idle slot after a flush keeps its eob clear of the next block's first word
    always_ff @(posedge xclk) begin
        if (rst)
            in_ready <= 1'b0;
        else
            in_ready <= space_ok && !(beat_fire && in_beat.op == vlc_pkg::OP_FLUSH);
    end

    bit_packer u_packer (
        .xclk       (xclk),
        .rst        (rst),
        .beat_valid (beat_fire),
        .beat       (in_beat),
        .word_valid (pk_valid),
        .word       (pk_word)
    );

    word_fifo u_fifo (
        .xclk      (xclk),
        .rst       (rst),
        .push      (pk_valid),
        .push_word (pk_word),
        .pop       (pop),
        .pop_valid (pop_valid),
        .pop_word  (pop_word),
        .space_ok  (space_ok)
    );

    byte_escaper u_escaper (
        .xclk      (xclk),
        .rst       (rst),
        .escape_en (escape_en),
        .pop_valid (pop_valid),
        .pop_word  (pop_word),
        .pop       (pop),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .byte_fire (byte_fire),
        .blk_done  (blk_done)
    );

    stream_ctrl_regs u_regs (
        .xclk      (xclk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .byte_fire (byte_fire),
        .blk_done  (blk_done),
        .escape_en (escape_en)
    );

endmodule

/* source/stream_ctrl_regs.sv */
////////////////////
// control and status registers
////////////////////
`timescale 1ns/100ps

module stream_ctrl_regs (
    input  logic               xclk,
    input  logic               rst,
    input  logic               cfg_we,
    input  vlc_pkg::reg_addr_t cfg_addr,
    input  logic [31:0]        cfg_wdata,
    output logic [31:0]        cfg_rdata,   // combinational read
    input  logic               byte_fire,
    input  logic               blk_done,
    output logic               escape_en
);

    logic [31:0] byte_cnt;                  // bytes out, stuffed zeros included
    logic [31:0] blk_cnt;                   // eob markers seen

    always_ff @(posedge xclk) begin
        if (rst) begin
            escape_en <= 1'b1;              // stuffing on by default
            byte_cnt  <= '0;
            blk_cnt   <= '0;
        end else begin
            if (cfg_we && cfg_addr == vlc_pkg::REG_CTRL)
                escape_en <= cfg_wdata[0];
            if (cfg_we && cfg_addr == vlc_pkg::REG_BYTES)
                byte_cnt <= '0;             // any write clears
            else if (byte_fire)
                byte_cnt <= byte_cnt + 1'b1;
            if (cfg_we && cfg_addr == vlc_pkg::REG_BLOCKS)
                blk_cnt <= '0;
            else if (blk_done)
                blk_cnt <= blk_cnt + 1'b1;
        end
    end

    always_comb begin
        case (cfg_addr)
            vlc_pkg::REG_CTRL:   cfg_rdata = {31'b0, escape_en};
            vlc_pkg::REG_BYTES:  cfg_rdata = byte_cnt;
            vlc_pkg::REG_BLOCKS: cfg_rdata = blk_cnt;
            default:             cfg_rdata = '0;
        endcase
    end

endmodule

/* source/byte_escaper.sv */
////////////////////
// word to byte splitter with 0xff zero stuffing
////////////////////
`timescale 1ns/100ps

module byte_escaper (
    input  logic                  xclk,
    input  logic                  rst,
    input  logic                  escape_en,    // stuff 0x00 after 0xff
    input  logic                  pop_valid,
    input  vlc_pkg::packed_word_t pop_word,
    output logic                  pop,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [7:0]            out_data,
    output logic                  byte_fire,    // any byte transferred, stuffed too
    output logic                  blk_done      // eob marker popped
);

    vlc_pkg::esc_state_t            state;
    logic [vlc_pkg::word_width-1:0] word_q;     // current byte in the top 8 bits
    logic [2:0]                     left;       // data bytes not yet sent
    logic                           last_byte;
    logic                           need_zero;

    assign pop       = (state == vlc_pkg::ESC_IDLE) && pop_valid;
    assign out_valid = (state != vlc_pkg::ESC_IDLE);
    assign out_data  = (state == vlc_pkg::ESC_ZERO) ? 8'h00
                                                    : word_q[vlc_pkg::word_width-1 -: 8];
    assign byte_fire = out_valid && out_ready;
    assign last_byte = (left == 3'd1);
    assign need_zero = escape_en && (word_q[vlc_pkg::word_width-1 -: 8] == 8'hff);

    always_ff @(posedge xclk) begin
        if (rst) begin
            state    <= vlc_pkg::ESC_IDLE;
            left     <= '0;
            blk_done <= 1'b0;
        end else begin
            blk_done <= pop && pop_word.eob;    // eob sends no byte
            case (state)
                vlc_pkg::ESC_IDLE: begin
                    if (pop && !pop_word.eob && pop_word.nbytes != 3'd0) begin
                        state <= vlc_pkg::ESC_BYTE;
                        left  <= pop_word.nbytes;
                    end
                end
                vlc_pkg::ESC_BYTE: begin
                    if (out_ready) begin
                        left <= left - 1'b1;
                        if (need_zero)
                            state <= vlc_pkg::ESC_ZERO;
                        else if (last_byte)
                            state <= vlc_pkg::ESC_IDLE;
                    end
                end
                vlc_pkg::ESC_ZERO: begin
                    if (out_ready)              // left already counts the 0xff as sent
                        state <= (left == 3'd0) ? vlc_pkg::ESC_IDLE : vlc_pkg::ESC_BYTE;
                end
                default: state <= vlc_pkg::ESC_IDLE;
            endcase
        end
    end

    always_ff @(posedge xclk) begin
        if (pop)
            word_q <= pop_word.data;
        else if (state == vlc_pkg::ESC_BYTE && out_ready)
            word_q <= word_q << 8;              // next byte up
    end

endmodule

/* source/word_fifo.sv */
////////////////////
// 16-entry fifo of packed words with free-space flag
////////////////////
`timescale 1ns/100ps

module word_fifo (
    input  logic                  xclk,
    input  logic                  rst,
    input  logic                  push,         // from packer, no backpressure
    input  vlc_pkg::packed_word_t push_word,
    input  logic                  pop,
    output logic                  pop_valid,
    output vlc_pkg::packed_word_t pop_word,
    output logic                  space_ok      // at least fifo_reserve entries free
);

    vlc_pkg::packed_word_t                   mem [vlc_pkg::fifo_depth];
    logic [$clog2(vlc_pkg::fifo_depth)-1:0] wr_ptr;
    logic [$clog2(vlc_pkg::fifo_depth)-1:0] rd_ptr;
    logic [$clog2(vlc_pkg::fifo_depth):0]   count;     // fill level 0..depth
    logic                                   do_push;
    logic                                   do_pop;

    assign do_push   = push && (count != vlc_pkg::fifo_depth);  // full drop never expected
    assign do_pop    = pop && pop_valid;
    assign pop_valid = (count != '0);
    assign pop_word  = mem[rd_ptr];
    assign space_ok  = (vlc_pkg::fifo_depth - int'(count)) >= vlc_pkg::fifo_reserve;

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or none
            endcase
        end
    end

    always_ff @(posedge xclk) begin
        if (do_push)
            mem[wr_ptr] <= push_word;
    end

endmodule

/* source/bit_packer.sv */
////////////////////
// three-stage barrel shifter packing codewords into 32-bit words
////////////////////
`timescale 1ns/100ps

module bit_packer (
    input  logic                  xclk,
    input  logic                  rst,
    input  logic                  beat_valid,   // beat transferred on this edge
    input  vlc_pkg::cw_beat_t     beat,
    output logic                  word_valid,   // pushes word into fifo
    output vlc_pkg::packed_word_t word
);

    logic                              cw_fire;    // codeword beat
    logic                              fl_fire;    // flush beat
    logic [4:0]                        pos;        // running bit position mod 32
    logic [5:0]                        pos_sum;    // bit 5 is carry out of the word
    logic [vlc_pkg::cw_width-1:0]      cw_clean;   // bits below len forced to zero

    logic                              s1_cw;
    logic                              s1_fl;
    logic                              s1_carry;
    logic [4:0]                        s1_pos;     // position before this beat
    logic [vlc_pkg::cw_width+23:0]     s1_data;    // shifted by 0/8/16/24

    logic                              s2_cw;
    logic                              s2_fl;
    logic                              s2_carry;
    logic [4:0]                        s2_pos;
    logic [vlc_pkg::cw_width+29:0]     s2_data;    // shifted by 0/2/4/6 more
    logic [vlc_pkg::word_width-1:0]    s2_mask;    // 1 takes new bits, 0 keeps held

    logic [vlc_pkg::cw_width+30:0]     placed;     // final 0/1 shift, two-word window
    logic [vlc_pkg::word_width-1:0]    merged;     // held word with new bits in
    logic [vlc_pkg::word_width-1:0]    acc;        // partial word being filled
    logic [5:0]                        rnd_bits;   // residue bits + 7 for byte round-up

    logic                              s3_fl;
    logic [vlc_pkg::word_width-1:0]    fl_data;    // residue waiting for output slot
    logic [2:0]                        fl_nbytes;
    logic                              s4_fl;      // eob marker next

    // mask of bits from position p to the lsb, byte table then byte shift
    function automatic logic [31:0] pos_mask(input logic [4:0] p);
        logic [7:0] m8;
        case (p[2:0])
            3'd0:    m8 = 8'hff;
            3'd1:    m8 = 8'h7f;
            3'd2:    m8 = 8'h3f;
            3'd3:    m8 = 8'h1f;
            3'd4:    m8 = 8'h0f;
            3'd5:    m8 = 8'h07;
            3'd6:    m8 = 8'h03;
            default: m8 = 8'h01;
        endcase
        return {m8, 24'hffffff} >> {p[4:3], 3'b000};
    endfunction

    assign cw_fire  = beat_valid && (beat.op == vlc_pkg::OP_CODE);
    assign fl_fire  = beat_valid && (beat.op == vlc_pkg::OP_FLUSH);
    assign pos_sum  = {1'b0, pos} + {1'b0, beat.len};
    assign cw_clean = beat.bits & ~({vlc_pkg::cw_width{1'b1}} >> beat.len);
    assign placed   = {s2_data, 1'b0} >> s2_pos[0];
    assign merged   = (acc & ~s2_mask) |
                      (placed[vlc_pkg::cw_width+30 -: vlc_pkg::word_width] & s2_mask);
    assign rnd_bits = {1'b0, s2_pos} + 6'd7;

    always_ff @(posedge xclk) begin
        if (rst) begin
            pos        <= '0;
            s1_cw      <= 1'b0;
            s1_fl      <= 1'b0;
            s2_cw      <= 1'b0;
            s2_fl      <= 1'b0;
            s3_fl      <= 1'b0;
            s4_fl      <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (fl_fire)
                pos <= '0;                  // next block starts at msb
            else if (cw_fire)
                pos <= pos_sum[4:0];
            s1_cw      <= cw_fire;
            s1_fl      <= fl_fire;
            s2_cw      <= s1_cw;
            s2_fl      <= s1_fl;
            s3_fl      <= s2_fl;
            s4_fl      <= s3_fl;
            word_valid <= (s2_cw && s2_carry) || (s3_fl && fl_nbytes != 3'd0) || s4_fl;
        end
    end

    always_ff @(posedge xclk) begin
        // stage 1, byte shift
        s1_pos   <= pos;                    // on flush this is the residue length
        s1_carry <= pos_sum[5];
        s1_data  <= {cw_clean, 24'b0} >> {pos[4:3], 3'b000};
        // stage 2, bit-pair shift and mask lookup
        s2_pos   <= s1_pos;
        s2_carry <= s1_carry;
        s2_data  <= {s1_data, 6'b0} >> {s1_pos[2:1], 1'b0};
        s2_mask  <= pos_mask(s1_pos);
        // stage 3, single-bit shift and merge
        if (s2_cw) begin
            if (s2_carry)                   // spill bits open the next word
                acc <= {placed[vlc_pkg::cw_width-2:0],
                        {(vlc_pkg::word_width-vlc_pkg::cw_width+1){1'b0}}};
            else
                acc <= merged;
        end else if (s2_fl) begin
            acc <= '0;
        end
        if (s2_fl) begin
            fl_data   <= acc;
            fl_nbytes <= rnd_bits[5:3];     // whole bytes, rounded up
        end
        // output register
        if (s2_cw && s2_carry) begin
            word.data   <= merged;
            word.nbytes <= 3'd4;
            word.eob    <= 1'b0;
        end else if (s3_fl) begin
            word.data   <= fl_data;         // already zero below the residue
            word.nbytes <= fl_nbytes;
            word.eob    <= 1'b0;
        end else if (s4_fl) begin
            word.data   <= '0;
            word.nbytes <= 3'd0;
            word.eob    <= 1'b1;
        end
    end

endmodule

/* source/vlc_pkg.sv */
////////////////////
// shared constants, opcodes and beat/word structs
// for the variable-length code packer
////////////////////
package vlc_pkg;

    localparam int cw_width     = 27;   // longest codeword in bits
    localparam int word_width   = 32;   // packed word width
    localparam int fifo_depth   = 16;   // word fifo entries
    localparam int fifo_reserve = 4;    // free entries needed before a beat is taken

    // input beat opcodes
    typedef enum logic {
        OP_CODE  = 1'b0,                // append codeword
        OP_FLUSH = 1'b1                 // close current block
    } cw_op_t;

    typedef struct packed {
        cw_op_t              op;
        logic [cw_width-1:0] bits;      // codeword, msb aligned
        logic [4:0]          len;       // 1..27, only for OP_CODE
    } cw_beat_t;

    typedef struct packed {
        logic [word_width-1:0] data;    // msb first
        logic [2:0]            nbytes;  // valid bytes from msb, 0..4
        logic                  eob;     // end of block, nbytes is 0
    } packed_word_t;

    typedef enum logic [1:0] {
        ESC_IDLE = 2'd0,                // waiting for a word
        ESC_BYTE = 2'd1,                // data byte on output
        ESC_ZERO = 2'd2                 // stuffed zero after 0xff
    } esc_state_t;

    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,              // bit 0 escape enable
        REG_BYTES  = 2'd1,              // output byte counter
        REG_BLOCKS = 2'd2               // completed block counter
    } reg_addr_t;

endpackage
